//--- source/isa_pkg.sv
package isa_pkg;

	localparam int STATUS_W = 8;

	// Bit positions in the status byte
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_V = 6;
	localparam int FLAG_N = 7;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_LDA, OP_LDX, OP_STA,
		OP_ADC, OP_SBC, OP_CMP,
		OP_AND, OP_ORA, OP_EOR,
		OP_INC, OP_DEC, OP_INX, OP_DEX,
		OP_TAX, OP_TXA,
		OP_SEC, OP_CLC,
		OP_JMP,
		OP_BCC, OP_BCS, OP_BNE, OP_BEQ,
		OP_BPL, OP_BMI, OP_BVC, OP_BVS
	} opcode_t;

	typedef enum logic [2:0] {
		MODE_IMP,	// No operand
		MODE_IMM,
		MODE_ZP,
		MODE_ZPX,
		MODE_ABS,
		MODE_ABX,
		MODE_REL	// Signed branch offset
	} addr_mode_t;

endpackage

//--- source/datapath_pkg.sv
package datapath_pkg;

	localparam int DATA_W = 8;

	// ALU operation for the current cycle
	typedef enum logic [2:0] {
		ALU_TXA,	// Pass A operand
		ALU_TXB,	// Pass B operand
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORA,
		ALU_EOR
	} alu_func_t;

	typedef enum logic [2:0] {
		A_CON,		// Constant zero
		A_ACC,
		A_X,
		A_DL,
		A_ADH,
		A_PCL,
		A_PCH
	} a_sel_t;

	typedef enum logic [1:0] {
		B_BUS,
		B_CON		// Constant one
	} b_sel_t;

	// Result destinations, more than one may be set
	localparam int DEST_W   = 7;
	localparam int DEST_BUS = 0;
	localparam int DEST_ACC = 1;
	localparam int DEST_X   = 2;
	localparam int DEST_ADL = 3;
	localparam int DEST_ADH = 4;
	localparam int DEST_PCL = 5;
	localparam int DEST_PCH = 6;

endpackage

//--- source/cycle_fsm.sv
module cycle_fsm import isa_pkg::*, datapath_pkg::*; (
	input  logic                sys,
	input  logic                rst_n_i,
	input  logic                bus_rdy_i,
	input  opcode_t             opcode_i,
	input  addr_mode_t          mode_i,
	input  logic [STATUS_W-1:0] status_i,
	input  logic                alu_cout_i,
	input  logic                dl_sign_i,
	output logic                exec_o,
	output logic                seq_we_o,
	output logic                pc_addr_oe_o,
	output logic                ad_addr_oe_o,
	output logic                pc_inc_o,
	output logic                pc_load_o,
	output logic                ins_we_o,
	output alu_func_t           seq_func_o,
	output a_sel_t              seq_a_sel_o,
	output b_sel_t              seq_b_sel_o,
	output logic [DEST_W-1:0]   seq_dest_o,
	output logic                seq_cin_clr_o
);

	typedef enum logic [3:0] {
		S_VEC_L, S_VEC_H, S_FETCH, S_DECODE,
		S_READ_H, S_READ_HP, S_EXECUTE, S_WRITE_BACK,
		S_BRANCH, S_BRANCH_OVF
	} seq_state_t;

	seq_state_t state, state_next;
	logic cout_prev;
	logic branch;

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i)
			cout_prev <= 1'b0;
		else
			cout_prev <= alu_cout_i;	// Carry of the previous cycle
	end

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i)
			state <= S_VEC_L;
		else if (bus_rdy_i)
			state <= state_next;
	end

	always_comb begin
		case (opcode_i)
			OP_BCC:  branch = !status_i[FLAG_C];
			OP_BCS:  branch = status_i[FLAG_C];
			OP_BNE:  branch = !status_i[FLAG_Z];
			OP_BEQ:  branch = status_i[FLAG_Z];
			OP_BPL:  branch = !status_i[FLAG_N];
			OP_BMI:  branch = status_i[FLAG_N];
			OP_BVC:  branch = !status_i[FLAG_V];
			OP_BVS:  branch = status_i[FLAG_V];
			default: branch = 1'b0;
		endcase
	end

	always_comb begin
		exec_o = 1'b0;
		seq_we_o = 1'b0;
		pc_addr_oe_o = 1'b0;
		ad_addr_oe_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		ins_we_o = 1'b0;
		seq_func_o = ALU_TXB;
		seq_a_sel_o = A_CON;
		seq_b_sel_o = B_BUS;
		seq_dest_o = '0;
		seq_cin_clr_o = 1'b0;
		state_next = state;

		case (state)
			S_VEC_L: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				seq_dest_o[DEST_ADL] = 1'b1;	// Vector low byte
				state_next = S_VEC_H;
			end
			S_VEC_H: begin
				pc_addr_oe_o = 1'b1;
				pc_load_o = 1'b1;
				seq_dest_o[DEST_ADH] = 1'b1;
				state_next = S_FETCH;
			end
			S_FETCH: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				ins_we_o = 1'b1;
				seq_func_o = ALU_TXA;	// Zero into ADH for zero page
				seq_dest_o[DEST_ADH] = 1'b1;
				state_next = S_DECODE;
			end
			S_DECODE: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				state_next = S_FETCH;
				case (mode_i)
					MODE_IMP: begin
						pc_inc_o = 1'b0;	// No operand byte to skip
						exec_o = 1'b1;
					end
					MODE_IMM: exec_o = 1'b1;
					MODE_ZP: begin
						seq_dest_o[DEST_ADL] = 1'b1;
						state_next = S_EXECUTE;
					end
					MODE_ZPX: begin
						seq_func_o = ALU_ADD;	// X + BUS into ADL, no page carry
						seq_a_sel_o = A_X;
						seq_cin_clr_o = 1'b1;
						seq_dest_o[DEST_ADL] = 1'b1;
						state_next = S_EXECUTE;
					end
					MODE_ABS: begin
						seq_dest_o[DEST_ADL] = 1'b1;
						state_next = S_READ_H;
					end
					MODE_ABX: begin
						seq_func_o = ALU_ADD;
						seq_a_sel_o = A_X;
						seq_cin_clr_o = 1'b1;
						seq_dest_o[DEST_ADL] = 1'b1;
						state_next = S_READ_H;
					end
					MODE_REL: begin
						if (branch) begin
							pc_inc_o = 1'b0;
							seq_func_o = ALU_ADD;	// PCL + offset
							seq_a_sel_o = A_PCL;
							seq_cin_clr_o = 1'b1;
							seq_dest_o[DEST_PCL] = 1'b1;
							state_next = S_BRANCH;
						end
					end
					default: ;
				endcase
			end
			S_READ_H: begin
				pc_addr_oe_o = 1'b1;
				seq_dest_o[DEST_ADH] = 1'b1;
				if (opcode_i == OP_JMP) begin
					pc_load_o = 1'b1;
					state_next = S_FETCH;
				end else begin
					pc_inc_o = 1'b1;
					if (mode_i == MODE_ABX && cout_prev)
						state_next = S_READ_HP;	// Index crossed a page
					else
						state_next = S_EXECUTE;
				end
			end
			S_READ_HP: begin
				ad_addr_oe_o = 1'b1;
				seq_func_o = ALU_ADD;	// ADH + 1
				seq_a_sel_o = A_ADH;
				seq_b_sel_o = B_CON;
				seq_cin_clr_o = 1'b1;
				seq_dest_o[DEST_ADH] = 1'b1;
				state_next = S_EXECUTE;
			end
			S_EXECUTE: begin
				ad_addr_oe_o = 1'b1;
				if (opcode_i == OP_INC || opcode_i == OP_DEC) begin
					state_next = S_WRITE_BACK;	// Operand read into DL first
				end else begin
					exec_o = 1'b1;
					state_next = S_FETCH;
				end
			end
			S_WRITE_BACK: begin
				ad_addr_oe_o = 1'b1;
				exec_o = 1'b1;
				seq_we_o = 1'b1;
				state_next = S_FETCH;
			end
			S_BRANCH: begin
				pc_addr_oe_o = 1'b1;
				seq_func_o = dl_sign_i ? ALU_SUB : ALU_ADD;	// PCH fix for page cross
				seq_a_sel_o = A_PCH;
				seq_b_sel_o = B_CON;
				seq_cin_clr_o = 1'b1;
				if (cout_prev ^ dl_sign_i) begin
					seq_dest_o[DEST_PCH] = 1'b1;
					state_next = S_BRANCH_OVF;
				end else begin
					pc_inc_o = 1'b1;
					state_next = S_FETCH;
				end
			end
			S_BRANCH_OVF: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				state_next = S_FETCH;
			end
			default: state_next = S_VEC_L;
		endcase
	end

endmodule

//--- source/operation_decode.sv
module operation_decode import isa_pkg::*, datapath_pkg::*; (
	input  opcode_t             opcode_i,
	input  addr_mode_t          mode_i,
	input  logic                exec_i,
	input  logic                seq_we_i,
	input  alu_func_t           seq_func_i,
	input  a_sel_t              seq_a_sel_i,
	input  b_sel_t              seq_b_sel_i,
	input  logic [DEST_W-1:0]   seq_dest_i,
	input  logic                seq_cin_clr_i,
	output logic                bus_we_o,
	output alu_func_t           alu_func_o,
	output a_sel_t              a_sel_o,
	output b_sel_t              b_sel_o,
	output logic [DEST_W-1:0]   dest_o,
	output logic                cin_clr_o,
	output logic [STATUS_W-1:0] flag_mask_o,
	output logic [STATUS_W-1:0] flag_set_o,
	output logic [STATUS_W-1:0] flag_clr_o
);

	localparam logic [STATUS_W-1:0] MASK_NZ   = (STATUS_W'(1) << FLAG_N) | (STATUS_W'(1) << FLAG_Z);
	localparam logic [STATUS_W-1:0] MASK_NZC  = MASK_NZ | (STATUS_W'(1) << FLAG_C);
	localparam logic [STATUS_W-1:0] MASK_NZCV = MASK_NZC | (STATUS_W'(1) << FLAG_V);

	logic op_we;
	logic mem_mode;

	// STA has no register form
	assign mem_mode = (mode_i != MODE_IMP) && (mode_i != MODE_IMM);
	assign bus_we_o = seq_we_i | op_we;

	always_comb begin
		alu_func_o = seq_func_i;
		a_sel_o = seq_a_sel_i;
		b_sel_o = seq_b_sel_i;
		dest_o = seq_dest_i;
		cin_clr_o = seq_cin_clr_i;
		flag_mask_o = '0;
		flag_set_o = '0;
		flag_clr_o = '0;
		op_we = 1'b0;

		if (exec_i) begin
			alu_func_o = ALU_TXB;
			a_sel_o = A_CON;
			b_sel_o = B_BUS;
			dest_o = '0;
			cin_clr_o = 1'b0;
			case (opcode_i)
				OP_LDA, OP_LDX: begin
					dest_o[DEST_ACC] = (opcode_i == OP_LDA);	// BUS into ACC or X
					dest_o[DEST_X] = (opcode_i == OP_LDX);
					flag_mask_o = MASK_NZ;
				end
				OP_STA: begin
					alu_func_o = ALU_TXA;	// ACC onto BUS
					a_sel_o = A_ACC;
					dest_o[DEST_BUS] = 1'b1;
					op_we = mem_mode;
				end
				OP_ADC, OP_SBC: begin
					alu_func_o = (opcode_i == OP_ADC) ? ALU_ADD : ALU_SUB;	// Carry in from C
					a_sel_o = A_ACC;
					dest_o[DEST_ACC] = 1'b1;
					flag_mask_o = MASK_NZCV;
				end
				OP_CMP: begin
					alu_func_o = ALU_SUB;	// Flags only
					a_sel_o = A_ACC;
					cin_clr_o = 1'b1;
					flag_mask_o = MASK_NZC;
				end
				OP_AND, OP_ORA, OP_EOR: begin
					case (opcode_i)
						OP_AND:  alu_func_o = ALU_AND;
						OP_ORA:  alu_func_o = ALU_ORA;
						default: alu_func_o = ALU_EOR;
					endcase
					a_sel_o = A_ACC;
					dest_o[DEST_ACC] = 1'b1;
					flag_mask_o = MASK_NZ;
				end
				OP_INC, OP_DEC: begin
					alu_func_o = (opcode_i == OP_INC) ? ALU_ADD : ALU_SUB;	// DL +/- 1
					a_sel_o = A_DL;
					b_sel_o = B_CON;
					cin_clr_o = 1'b1;
					dest_o[DEST_BUS] = 1'b1;
					flag_mask_o = MASK_NZ;
				end
				OP_INX, OP_DEX: begin
					alu_func_o = (opcode_i == OP_INX) ? ALU_ADD : ALU_SUB;
					a_sel_o = A_X;
					b_sel_o = B_CON;
					cin_clr_o = 1'b1;
					dest_o[DEST_X] = 1'b1;
					flag_mask_o = MASK_NZ;
				end
				OP_TAX: begin
					alu_func_o = ALU_TXA;
					a_sel_o = A_ACC;
					dest_o[DEST_X] = 1'b1;
					flag_mask_o = MASK_NZ;
				end
				OP_TXA: begin
					alu_func_o = ALU_TXA;
					a_sel_o = A_X;
					dest_o[DEST_ACC] = 1'b1;
					flag_mask_o = MASK_NZ;
				end
				OP_SEC: flag_set_o[FLAG_C] = 1'b1;
				OP_CLC: flag_clr_o[FLAG_C] = 1'b1;
				default: ;	// JMP, branches and NOP do nothing here
			endcase
		end
	end

endmodule

//--- source/sequencer_top.sv
module sequencer_top import isa_pkg::*, datapath_pkg::*; (
	input  logic                sys,
	input  logic                rst_n_i,
	input  logic                bus_rdy_i,
	input  opcode_t             opcode_i,
	input  addr_mode_t          mode_i,
	input  logic [STATUS_W-1:0] status_i,
	input  logic                alu_cout_i,
	input  logic                dl_sign_i,
	output logic                exec_o,
	output logic                bus_we_o,
	output logic                pc_addr_oe_o,
	output logic                ad_addr_oe_o,
	output logic                pc_inc_o,
	output logic                pc_load_o,
	output logic                ins_we_o,
	output alu_func_t           alu_func_o,
	output a_sel_t              a_sel_o,
	output b_sel_t              b_sel_o,
	output logic [DEST_W-1:0]   dest_o,
	output logic                cin_clr_o,
	output logic [STATUS_W-1:0] flag_mask_o,
	output logic [STATUS_W-1:0] flag_set_o,
	output logic [STATUS_W-1:0] flag_clr_o
);

	// Address phase fields from the FSM
	logic              seq_we;
	alu_func_t         seq_func;
	a_sel_t            seq_a_sel;
	b_sel_t            seq_b_sel;
	logic [DEST_W-1:0] seq_dest;
	logic              seq_cin_clr;

	cycle_fsm u_cycle_fsm (
		.sys(sys), .rst_n_i(rst_n_i), .bus_rdy_i(bus_rdy_i),
		.opcode_i(opcode_i), .mode_i(mode_i), .status_i(status_i),
		.alu_cout_i(alu_cout_i), .dl_sign_i(dl_sign_i),
		.exec_o(exec_o), .seq_we_o(seq_we),
		.pc_addr_oe_o(pc_addr_oe_o), .ad_addr_oe_o(ad_addr_oe_o),
		.pc_inc_o(pc_inc_o), .pc_load_o(pc_load_o), .ins_we_o(ins_we_o),
		.seq_func_o(seq_func), .seq_a_sel_o(seq_a_sel), .seq_b_sel_o(seq_b_sel),
		.seq_dest_o(seq_dest), .seq_cin_clr_o(seq_cin_clr)
	);

	operation_decode u_operation_decode (
		.opcode_i(opcode_i), .mode_i(mode_i), .exec_i(exec_o), .seq_we_i(seq_we),
		.seq_func_i(seq_func), .seq_a_sel_i(seq_a_sel), .seq_b_sel_i(seq_b_sel),
		.seq_dest_i(seq_dest), .seq_cin_clr_i(seq_cin_clr),
		.bus_we_o(bus_we_o), .alu_func_o(alu_func_o), .a_sel_o(a_sel_o),
		.b_sel_o(b_sel_o), .dest_o(dest_o), .cin_clr_o(cin_clr_o),
		.flag_mask_o(flag_mask_o), .flag_set_o(flag_set_o), .flag_clr_o(flag_clr_o)
	);

endmodule

//--- sim/sequencer_properties.sv
module sequencer_properties (
	input logic                sys,
	input logic                rst_n_i,
	input logic                bus_rdy_i,
	input logic                exec_o,
	input logic                bus_we_o,
	input logic                pc_addr_oe_o,
	input logic                ad_addr_oe_o,
	input logic                pc_inc_o,
	input logic                pc_load_o,
	input logic                ins_we_o,
	input logic [2:0]          alu_func_o,
	input logic [2:0]          a_sel_o,
	input logic [1:0]          b_sel_o,
	input logic [6:0]          dest_o,
	input logic                cin_clr_o,
	input logic [7:0]          flag_mask_o,
	input logic [7:0]          flag_set_o,
	input logic [7:0]          flag_clr_o
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [46:0] ctrl;

	assign ctrl = {exec_o, bus_we_o, pc_addr_oe_o, ad_addr_oe_o, pc_inc_o, pc_load_o,
		ins_we_o, alu_func_o, a_sel_o, b_sel_o, dest_o, cin_clr_o,
		flag_mask_o, flag_set_o, flag_clr_o};

	// Only one address source drives the bus
	addr_src_excl: assert property (@(posedge sys) disable iff (!rst_n_i)
		!(pc_addr_oe_o && ad_addr_oe_o)) else $error("Both address sources enabled");

	write_uses_ad: assert property (@(posedge sys) disable iff (!rst_n_i)
		bus_we_o |-> ad_addr_oe_o) else $error("Write without data address");

	load_fetch_excl: assert property (@(posedge sys) disable iff (!rst_n_i)
		!(pc_load_o && ins_we_o)) else $error("PC load during fetch");

	stall_hold: assert property (@(posedge sys) disable iff (!rst_n_i)
		!bus_rdy_i |=> $stable(ctrl)) else $error("Controls moved during a stall");

endmodule

//--- sim/sequencer_tb.sv
module sequencer_tb import isa_pkg::*, datapath_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROUNDS = 10;
	localparam int NTESTS = ROUNDS * 26;

	typedef struct packed {
		logic [3:0]          cycles;
		logic                exec;
		alu_func_t           func;
		a_sel_t              a_sel;
		b_sel_t              b_sel;
		logic [DEST_W-1:0]   dest;
		logic                cin_clr;
		logic                we;
		logic [STATUS_W-1:0] f_mask;
		logic [STATUS_W-1:0] f_set;
		logic [STATUS_W-1:0] f_clr;
	} expect_t;

	logic sys, rst_n_i, bus_rdy_i, alu_cout_i, dl_sign_i;
	opcode_t opcode_i;
	addr_mode_t mode_i;
	logic [STATUS_W-1:0] status_i;
	logic exec_o, bus_we_o, pc_addr_oe_o, ad_addr_oe_o, pc_inc_o, pc_load_o, ins_we_o;
	alu_func_t alu_func_o;
	a_sel_t a_sel_o;
	b_sel_t b_sel_o;
	logic [DEST_W-1:0] dest_o;
	logic cin_clr_o;
	logic [STATUS_W-1:0] flag_mask_o, flag_set_o, flag_clr_o;

	expect_t exp_q[$];
	opcode_t op_q[$];
	addr_mode_t mode_q[$];
	int errors = 0;
	int cycle_cnt = 0;
	int limit = 2 * 12;	// Reset and vector load
	logic stall_en = 1'b0;

	sequencer_top UUT (.*);

	bind sequencer_top sequencer_properties u_props (.*);

	always #10 sys = ~sys;

	function automatic addr_mode_t pick_mode(opcode_t op, int r);
		case (op)
			OP_INX, OP_DEX, OP_TAX, OP_TXA, OP_SEC, OP_CLC: return MODE_IMP;
			OP_JMP: return MODE_ABS;
			OP_BCC, OP_BCS, OP_BNE, OP_BEQ, OP_BPL, OP_BMI, OP_BVC, OP_BVS: return MODE_REL;
			OP_LDX: return (r % 3 == 0) ? MODE_IMM : ((r % 3 == 1) ? MODE_ZP : MODE_ABS);
			OP_STA, OP_INC, OP_DEC: return addr_mode_t'(MODE_ZP + r % 4);	// No immediate form
			default: return addr_mode_t'(MODE_IMM + r % 5);
		endcase
	endfunction

	function automatic expect_t ref_model(opcode_t op, addr_mode_t md,
		logic [STATUS_W-1:0] st, logic cy, logic sg);
		expect_t e;
		logic [STATUS_W-1:0] nz;
		logic f;
		logic taken;
		e = '0;
		e.func = ALU_TXB;
		e.a_sel = A_CON;
		e.b_sel = B_BUS;
		e.exec = 1'b1;
		nz = '0;
		nz[FLAG_N] = 1'b1;
		nz[FLAG_Z] = 1'b1;
		case (md)
			MODE_IMP, MODE_IMM: e.cycles = 2;
			MODE_ZP, MODE_ZPX:  e.cycles = 3;
			MODE_ABS:           e.cycles = 4;
			default:            e.cycles = cy ? 5 : 4;	// Absolute X page cross
		endcase
		case (op)
			OP_BCC, OP_BCS: f = st[FLAG_C];
			OP_BNE, OP_BEQ: f = st[FLAG_Z];
			OP_BPL, OP_BMI: f = st[FLAG_N];
			default:        f = st[FLAG_V];
		endcase
		taken = (op == OP_BCS || op == OP_BEQ || op == OP_BMI || op == OP_BVS) ? f : !f;
		case (op)
			OP_LDA: begin
				e.dest[DEST_ACC] = 1'b1;
				e.f_mask = nz;
			end
			OP_LDX: begin
				e.dest[DEST_X] = 1'b1;
				e.f_mask = nz;
			end
			OP_STA: begin
				e.func = ALU_TXA;
				e.a_sel = A_ACC;
				e.dest[DEST_BUS] = 1'b1;
				e.we = 1'b1;
			end
			OP_ADC, OP_SBC: begin
				e.func = (op == OP_ADC) ? ALU_ADD : ALU_SUB;
				e.a_sel = A_ACC;
				e.dest[DEST_ACC] = 1'b1;
				e.f_mask = nz;
				e.f_mask[FLAG_C] = 1'b1;
				e.f_mask[FLAG_V] = 1'b1;
			end
			OP_CMP: begin
				e.func = ALU_SUB;
				e.a_sel = A_ACC;
				e.cin_clr = 1'b1;
				e.f_mask = nz;
				e.f_mask[FLAG_C] = 1'b1;
			end
			OP_AND, OP_ORA, OP_EOR: begin
				e.func = (op == OP_AND) ? ALU_AND : ((op == OP_ORA) ? ALU_ORA : ALU_EOR);
				e.a_sel = A_ACC;
				e.dest[DEST_ACC] = 1'b1;
				e.f_mask = nz;
			end
			OP_INC, OP_DEC, OP_INX, OP_DEX: begin
				e.func = (op == OP_INC || op == OP_INX) ? ALU_ADD : ALU_SUB;
				e.a_sel = (op == OP_INC || op == OP_DEC) ? A_DL : A_X;
				e.b_sel = B_CON;
				e.cin_clr = 1'b1;
				e.f_mask = nz;
				if (op == OP_INC || op == OP_DEC) begin
					e.dest[DEST_BUS] = 1'b1;
					e.we = 1'b1;
					e.cycles = e.cycles + 1;	// Write back cycle
				end else begin
					e.dest[DEST_X] = 1'b1;
				end
			end
			OP_TAX, OP_TXA: begin
				e.func = ALU_TXA;
				e.a_sel = (op == OP_TAX) ? A_ACC : A_X;
				e.dest[(op == OP_TAX) ? DEST_X : DEST_ACC] = 1'b1;
				e.f_mask = nz;
			end
			OP_SEC: e.f_set[FLAG_C] = 1'b1;
			OP_CLC: e.f_clr[FLAG_C] = 1'b1;
			OP_JMP: begin
				e.exec = 1'b0;
				e.cycles = 3;
			end
			default: begin
				e.exec = 1'b0;	// Branches
				e.cycles = !taken ? 2 : ((cy ^ sg) ? 4 : 3);
			end
		endcase
		return e;
	endfunction

	task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			$display("Fail %s: got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	initial begin : stimulus
		opcode_t op;
		addr_mode_t md;
		expect_t e;
		void'($urandom(32'ha8e6_3c97));
		sys = 1'b0;
		rst_n_i = 1'b0;
		bus_rdy_i = 1'b1;
		opcode_i = OP_NOP;
		mode_i = MODE_IMP;
		status_i = '0;
		alu_cout_i = 1'b0;
		dl_sign_i = 1'b0;
		repeat (8) @(posedge sys);
		rst_n_i <= 1'b1;
		for (int t = 0; t < NTESTS; t++) begin
			@(negedge sys);
			while (!(ins_we_o && bus_rdy_i))
				@(negedge sys);
			@(posedge sys);
			op = opcode_t'(1 + t % 26);
			md = pick_mode(op, t / 26);
			status_i <= STATUS_W'($urandom);
			alu_cout_i <= 1'($urandom);
			dl_sign_i <= 1'($urandom);
			opcode_i <= op;
			mode_i <= md;
			#1;
			e = ref_model(op, md, status_i, alu_cout_i, dl_sign_i);
			exp_q.push_back(e);
			op_q.push_back(op);
			mode_q.push_back(md);
			limit += 2 * int'(e.cycles);
			stall_en <= 1'b1;
		end
	end

	always @(posedge sys) begin : stall_gen
		logic rdy;
		rdy = ($urandom_range(3, 0) != 0);
		if (stall_en) begin
			bus_rdy_i <= rdy;
			if (!rdy)
				limit += 1;
		end
	end

	always @(posedge sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > limit) begin
			$display("Timeout: run went past %0d cycles", limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin : compare
		expect_t e;
		opcode_t op;
		addr_mode_t md;
		int cycles;
		int stalls;
		int idx;
		logic exp_exec;
		int err0;
		@(posedge rst_n_i);
		@(negedge sys);
		check_field("pc_load_o", pc_load_o, 0);
		check_field("ins_we_o", ins_we_o, 0);
		check_field("exec_o", exec_o, 0);
		check_field("bus_we_o", bus_we_o, 0);
		check_field("ad_addr_oe_o", ad_addr_oe_o, 0);
		check_field("pc_addr_oe_o", pc_addr_oe_o, 1);
		check_field("pc_inc_o", pc_inc_o, 1);
		@(negedge sys);
		check_field("pc_load_o", pc_load_o, 1);
		check_field("ins_we_o", ins_we_o, 0);
		@(negedge sys);
		check_field("ins_we_o", ins_we_o, 1);
		$display("Test reset vector done, errors %0d", errors);
		for (int t = 0; t < NTESTS; t++) begin
			while (!(ins_we_o && bus_rdy_i))
				@(negedge sys);
			cycles = 1;
			stalls = 0;
			err0 = errors;
			@(negedge sys);
			e = exp_q.pop_front();
			op = op_q.pop_front();
			md = mode_q.pop_front();
			while (!ins_we_o) begin
				cycles++;
				idx = cycles - stalls;	// Position in the instruction without stalls
				exp_exec = e.exec && (idx == int'(e.cycles));	// Exec is the last cycle
				if (!bus_rdy_i)
					stalls++;
				check_field("exec_o", exec_o, exp_exec);
				if (exp_exec) begin
					check_field("alu_func_o", alu_func_o, e.func);
					check_field("a_sel_o", a_sel_o, e.a_sel);
					check_field("b_sel_o", b_sel_o, e.b_sel);
					check_field("dest_o", dest_o, e.dest);
					check_field("cin_clr_o", cin_clr_o, e.cin_clr);
					check_field("flag_mask_o", flag_mask_o, e.f_mask);
					check_field("flag_set_o", flag_set_o, e.f_set);
					check_field("flag_clr_o", flag_clr_o, e.f_clr);
				end
				check_field("bus_we_o", bus_we_o, exp_exec && e.we);
				@(negedge sys);
			end
			check_field("cycle count", cycles, int'(e.cycles) + stalls);
			$display("Test %0d %s %s cycles %0d stalls %0d %s", t, op.name(), md.name(),
				cycles, stalls, (errors == err0) ? "ok" : "failed");
		end
		$display("Tests %0d, errors %0d", NTESTS + 1, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- files.f
source/isa_pkg.sv
source/datapath_pkg.sv
source/cycle_fsm.sv
source/operation_decode.sv
source/sequencer_top.sv
sim/sequencer_properties.sv
sim/sequencer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module sequencer_tb -o simv
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation run returned an error"
	exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
